//--- sel_params.svh
// widths and addresses shared by the selection core; depth bits must be 2 or more
`ifndef SEL_PARAMS_SVH
`define SEL_PARAMS_SVH

// log2 of the FIFO register count
// one register less than 2**bits is usable
`define SEL_FIFO_DEPTH_BITS 2

// matched and dropped counters, saturating
`define SEL_CNT_W 16

// register map, 2-bit word addresses
// ctrl holds the predicate opcode in bits 1:0
`define SEL_ADDR_CTRL 2'd0
// compare constant in bits 15:0
`define SEL_ADDR_CONST 2'd1
// counters are read only
`define SEL_ADDR_MATCHED 2'd2
`define SEL_ADDR_DROPPED 2'd3

`endif

//--- stream_pkg.sv
// tuple layout is fixed at a 16-bit key over a 32-bit value; keys compare unsigned
package stream_pkg;

  // one row of the stream
  // key sits in the upper bits of the 48-bit word
  typedef struct packed {
    logic [15:0] key;
    logic [31:0] value;
  } tuple_t;

  // predicate opcodes as held in the ctrl register
  // pass_all lets every tuple through, the rest compare key against the constant
  typedef enum logic [1:0] {
    // reset value
    pass_all = 2'd0,
    // key < constant
    less     = 2'd1,
    // key == constant
    equal    = 2'd2,
    // key > constant
    greater  = 2'd3
  } pred_op_t;

endpackage

//--- cfg_pkg.sv
// register port types for the selection core; depends on stream_pkg being compiled first
package cfg_pkg;

  // register write, accepted in the cycle it is valid
  typedef struct packed {
    logic [1:0]  addr;
    logic [31:0] data;
  } reg_wr_t;

  // register read request
  // data comes back one cycle later on a separate 32-bit word
  typedef struct packed {
    logic [1:0] addr;
  } reg_rd_t;

  // live predicate seen by the filter
  typedef struct packed {
    stream_pkg::pred_op_t op;
    logic [15:0]          constant;
  } pred_cfg_t;

endpackage

//--- reg_fifo.sv
// holds 2**depth_bits-1 entries; out_data is only meaningful while out_valid is high
`timescale 1ns/1ps

module reg_fifo #(
  parameter type payload_t  = logic [31:0],
  parameter int  depth_bits = 2
) (
  input  logic     clk,
  input  logic     rst_n,
  // write side
  input  payload_t in_data,
  input  logic     in_valid,
  output logic     in_ready,
  // read side, head of the chain
  output payload_t out_data,
  output logic     out_valid,
  input  logic     out_ready
);

  localparam int num_regs = 2 ** depth_bits;

  // register chain, index 0 is the head
  payload_t            data_q [num_regs];
  logic [num_regs-1:0] valid_q;
  // valid of the neighbour above, zero past the top
  logic [num_regs:0]   valid_up;
  // valid of the neighbour below, the head always counts as having one
  logic [num_regs:0]   valid_dn;
  // holds ready low through reset and for the first cycle after
  logic                live_q;
  logic                wr;
  logic                rd;

  if (depth_bits < 2) begin : g_bad_depth
    $error("reg_fifo needs depth_bits of at least 2");
  end

  assign valid_up = {1'b0, valid_q};
  assign valid_dn = {valid_q, 1'b1};

  // ready depends on state only
  // drops once the second-to-last register is taken
  assign in_ready = live_q & ~valid_q[num_regs-2];

  assign wr = in_valid & in_ready;
  assign rd = valid_q[0] & out_ready;

  always_ff @(posedge clk) begin
    if (!rst_n) begin
      live_q <= 1'b0;
    end else begin
      live_q <= 1'b1;
    end
  end

  for (genvar i = 0; i < num_regs; i++) begin : g_reg
    // this register is the lowest free slot after any shift this cycle
    logic fill;
    // occupancy carried over from the chain, before any write
    logic keep;

    // on a read the chain moves down one, so the old last entry's slot opens
    assign fill = rd ? (valid_q[i] & ~valid_up[i+1]) : (~valid_q[i] & valid_dn[i]);
    assign keep = rd ? valid_up[i+1] : valid_q[i];

    always_ff @(posedge clk) begin
      if (!rst_n) begin
        valid_q[i] <= 1'b0;
      end else begin
        valid_q[i] <= keep | (fill & wr);
      end
    end

    if (i < num_regs - 1) begin : g_body
      // shift toward the head on a read, else take new data if this is the free slot
      always_ff @(posedge clk) begin
        if (rd && valid_q[i+1]) begin
          data_q[i] <= data_q[i+1];
        end else if (fill && wr) begin
          data_q[i] <= in_data;
        end
      end
    end else begin : g_top
      // nothing above to shift in
      always_ff @(posedge clk) begin
        if (fill && wr) begin
          data_q[i] <= in_data;
        end
      end
    end
  end

  assign out_data  = data_q[0];
  assign out_valid = valid_q[0];

  // a stalled head keeps its data and stays valid
  a_out_hold: assert property (
    @(posedge clk) disable iff (!rst_n)
    out_valid && !out_ready |=> out_valid && $stable(out_data)
  ) else $error("reg_fifo head changed while stalled");

  // every reset edge empties the chain
  a_rst_empty: assert property (
    @(posedge clk) !rst_n |=> !out_valid
  ) else $error("reg_fifo out_valid high after reset edge");

endmodule

//--- select_cfg.sv
// configuration is written only while the pipeline is idle; reg_rd_data holds the last read
`timescale 1ns/1ps
`include "sel_params.svh"

module select_cfg (
  input  logic                   clk,
  input  logic                   rst_n,
  // register write port
  input  cfg_pkg::reg_wr_t       reg_wr,
  input  logic                   reg_wr_valid,
  // register read port
  input  cfg_pkg::reg_rd_t       reg_rd,
  input  logic                   reg_rd_valid,
  output logic [31:0]            reg_rd_data,
  output logic                   reg_rd_ack,
  // predicate to the filter
  output cfg_pkg::pred_cfg_t     pred_cfg,
  // running totals from the filter
  input  logic [`SEL_CNT_W-1:0]  matched_cnt,
  input  logic [`SEL_CNT_W-1:0]  dropped_cnt
);

  // ctrl and const registers
  // takes effect on the filter one cycle after the write
  always_ff @(posedge clk) begin
    if (!rst_n) begin
      pred_cfg.op       <= stream_pkg::pass_all;
      pred_cfg.constant <= '0;
    end else if (reg_wr_valid) begin
      case (reg_wr.addr)
        `SEL_ADDR_CTRL: pred_cfg.op <= stream_pkg::pred_op_t'(reg_wr.data[1:0]);
        `SEL_ADDR_CONST: pred_cfg.constant <= reg_wr.data[15:0];
        // counter addresses are read only
        default: ;
      endcase
    end
  end

  // ack one cycle behind the request
  always_ff @(posedge clk) begin
    if (!rst_n) begin
      reg_rd_ack <= 1'b0;
    end else begin
      reg_rd_ack <= reg_rd_valid;
    end
  end

  // registered read mux, all fields zero extended
  always_ff @(posedge clk) begin
    if (reg_rd_valid) begin
      case (reg_rd.addr)
        `SEL_ADDR_CTRL: reg_rd_data <= {30'd0, pred_cfg.op};
        `SEL_ADDR_CONST: reg_rd_data <= {16'd0, pred_cfg.constant};
        `SEL_ADDR_MATCHED: reg_rd_data <= 32'(matched_cnt);
        `SEL_ADDR_DROPPED: reg_rd_data <= 32'(dropped_cnt);
      endcase
    end
  end

endmodule

//--- select_filter.sv
// compares keys unsigned against a constant that must not change while tuples are in flight
`timescale 1ns/1ps
`include "sel_params.svh"

module select_filter (
  input  logic                  clk,
  input  logic                  rst_n,
  // tuples from the input FIFO
  input  stream_pkg::tuple_t    in_data,
  input  logic                  in_valid,
  output logic                  in_ready,
  // matching tuples to the output FIFO
  output stream_pkg::tuple_t    out_data,
  output logic                  out_valid,
  input  logic                  out_ready,
  // predicate from the config block
  input  cfg_pkg::pred_cfg_t    pred_cfg,
  // saturating totals
  output logic [`SEL_CNT_W-1:0] matched_cnt,
  output logic [`SEL_CNT_W-1:0] dropped_cnt
);

  logic                accept;
  logic                hit;
  // sum of both counters, one bit wider so it cannot wrap
  logic [`SEL_CNT_W:0] total;

  // output register empty, or emptying this cycle
  assign in_ready = ~out_valid | out_ready;
  assign accept   = in_valid & in_ready;

  // predicate on the incoming key
  always_comb begin
    unique case (pred_cfg.op)
      stream_pkg::pass_all: hit = 1'b1;
      stream_pkg::less:     hit = in_data.key < pred_cfg.constant;
      stream_pkg::equal:    hit = in_data.key == pred_cfg.constant;
      stream_pkg::greater:  hit = in_data.key > pred_cfg.constant;
    endcase
  end

  // output register valid
  // a dropped tuple leaves it empty once any held tuple has left
  always_ff @(posedge clk) begin
    if (!rst_n) begin
      out_valid <= 1'b0;
    end else if (accept) begin
      out_valid <= hit;
    end else if (out_ready) begin
      out_valid <= 1'b0;
    end
  end

  // payload loads for matches only
  always_ff @(posedge clk) begin
    if (accept && hit) begin
      out_data <= in_data;
    end
  end

  // both counters bump on the accept edge and stick at all ones
  always_ff @(posedge clk) begin
    if (!rst_n) begin
      matched_cnt <= '0;
      dropped_cnt <= '0;
    end else if (accept) begin
      if (hit && matched_cnt != '1) begin
        matched_cnt <= matched_cnt + 1'b1;
      end
      if (!hit && dropped_cnt != '1) begin
        dropped_cnt <= dropped_cnt + 1'b1;
      end
    end
  end

  assign total = {1'b0, matched_cnt} + {1'b0, dropped_cnt};

  // below saturation every accepted tuple lands in exactly one counter
  a_cnt_step: assert property (
    @(posedge clk) disable iff (!rst_n)
    matched_cnt != '1 && dropped_cnt != '1 |=> total == $past(total) + $past(accept)
  ) else $error("select_filter counters out of step with accepts");

endmodule

//--- select_top.sv
// software writes configuration only while the pipeline is idle; ready rises a cycle after reset
`timescale 1ns/1ps
`include "sel_params.svh"

module select_top (
  input  logic               clk,
  input  logic               rst_n,
  // tuple input stream
  input  stream_pkg::tuple_t in_data,
  input  logic               in_valid,
  output logic               in_ready,
  // tuple output stream
  output stream_pkg::tuple_t out_data,
  output logic               out_valid,
  input  logic               out_ready,
  // register access
  input  cfg_pkg::reg_wr_t   reg_wr,
  input  logic               reg_wr_valid,
  input  cfg_pkg::reg_rd_t   reg_rd,
  input  logic               reg_rd_valid,
  output logic [31:0]        reg_rd_data,
  output logic               reg_rd_ack
);

  // input FIFO to filter
  stream_pkg::tuple_t    fifo_data;
  logic                  fifo_valid;
  logic                  fifo_ready;
  // filter to output FIFO
  stream_pkg::tuple_t    filt_data;
  logic                  filt_valid;
  logic                  filt_ready;
  // config and status between filter and register block
  cfg_pkg::pred_cfg_t    pred_cfg;
  logic [`SEL_CNT_W-1:0] matched_cnt;
  logic [`SEL_CNT_W-1:0] dropped_cnt;

  reg_fifo #(
    .payload_t  (stream_pkg::tuple_t),
    .depth_bits (`SEL_FIFO_DEPTH_BITS)
  ) in_fifo (
    .clk       (clk),
    .rst_n     (rst_n),
    .in_data   (in_data),
    .in_valid  (in_valid),
    .in_ready  (in_ready),
    .out_data  (fifo_data),
    .out_valid (fifo_valid),
    .out_ready (fifo_ready)
  );

  select_filter filter (
    .clk         (clk),
    .rst_n       (rst_n),
    .in_data     (fifo_data),
    .in_valid    (fifo_valid),
    .in_ready    (fifo_ready),
    .out_data    (filt_data),
    .out_valid   (filt_valid),
    .out_ready   (filt_ready),
    .pred_cfg    (pred_cfg),
    .matched_cnt (matched_cnt),
    .dropped_cnt (dropped_cnt)
  );

  // same FIFO, decoupling the sink from the filter
  reg_fifo #(
    .payload_t  (stream_pkg::tuple_t),
    .depth_bits (`SEL_FIFO_DEPTH_BITS)
  ) out_fifo (
    .clk       (clk),
    .rst_n     (rst_n),
    .in_data   (filt_data),
    .in_valid  (filt_valid),
    .in_ready  (filt_ready),
    .out_data  (out_data),
    .out_valid (out_valid),
    .out_ready (out_ready)
  );

  select_cfg cfg (
    .clk          (clk),
    .rst_n        (rst_n),
    .reg_wr       (reg_wr),
    .reg_wr_valid (reg_wr_valid),
    .reg_rd       (reg_rd),
    .reg_rd_valid (reg_rd_valid),
    .reg_rd_data  (reg_rd_data),
    .reg_rd_ack   (reg_rd_ack),
    .pred_cfg     (pred_cfg),
    .matched_cnt  (matched_cnt),
    .dropped_cnt  (dropped_cnt)
  );

endmodule

//--- select_tb.sv
// drives select_top from a fixed seed; config writes only happen once the expected queue is empty
`timescale 1ns/1ps
`include "sel_params.svh"

module select_tb;

  // 20 pass-all, 3 x 30 predicate, 40 under back-pressure
  localparam int n_tuples = 20 + 3 * 30 + 40;
  // per-tuple budget plus register traffic, with room for each drain of both FIFOs
  localparam int cycle_limit = 4 * n_tuples + 200 + 8 * (2 ** `SEL_FIFO_DEPTH_BITS);

  logic               clk;
  logic               rst_n;
  stream_pkg::tuple_t in_data;
  logic               in_valid;
  logic               in_ready;
  stream_pkg::tuple_t out_data;
  logic               out_valid;
  logic               out_ready = 1'b1;
  cfg_pkg::reg_wr_t   reg_wr;
  logic               reg_wr_valid;
  cfg_pkg::reg_rd_t   reg_rd;
  logic               reg_rd_valid;
  logic [31:0]        reg_rd_data;
  logic               reg_rd_ack;

  // scoreboard, rd_idx walks the expected tuples as they leave
  stream_pkg::tuple_t   exp_q [$];
  int                   rd_idx = 0;
  int                   matched_model = 0;
  int                   dropped_model = 0;
  stream_pkg::pred_op_t cur_op = stream_pkg::pass_all;
  logic [15:0]          cur_const = '0;
  logic                 stall_on = 1'b0;
  string                test_name = "reset";
  int                   cycles = 0;
  int                   n_tests = 0;
  int                   n_xfers = 0;
  int                   n_reg_checks = 0;
  // one error count per checking process
  int                   err_order = 0;
  int                   err_hold = 0;
  int                   err_ack = 0;
  int                   err_reg = 0;

  select_top dut (.*);

  initial begin
    clk = 1'b0;
    forever #5 clk = ~clk;
  end

  // hard stop if the pipeline wedges
  always @(posedge clk) begin
    cycles <= cycles + 1;
    if (cycles >= cycle_limit) begin
      $display("timeout: run stopped after %0d cycles in test %s", cycles, test_name);
      $display("CHECKS FAILED");
      $finish;
    end
  end

  // sink, ready 3 cycles in 4 while stalls are on
  always @(posedge clk) begin
    #1;
    out_ready = stall_on ? ($urandom_range(0, 3) != 0) : 1'b1;
  end

  // advance past each delivered tuple
  always @(posedge clk) begin
    if (rst_n && out_valid && out_ready) begin
      rd_idx  <= rd_idx + 1;
      n_xfers <= n_xfers + 1;
    end
  end

  // each output transfer must match the oldest outstanding expected tuple
  a_order: assert property (
    @(posedge clk) disable iff (!rst_n)
    out_valid && out_ready |-> rd_idx < exp_q.size() && out_data == exp_q[rd_idx]
  ) else begin
    if ($sampled(rd_idx) >= exp_q.size())
      $display("%s: tuple %h came out with nothing expected", test_name, $sampled(out_data));
    else
      $display("error %s expected %h actual %h", test_name, exp_q[$sampled(rd_idx)],
               $sampled(out_data));
    err_order++;
  end

  a_hold: assert property (
    @(posedge clk) disable iff (!rst_n)
    out_valid && !out_ready |=> out_valid && $stable(out_data)
  ) else begin
    $display("%s: output tuple changed or vanished while stalled", test_name);
    err_hold++;
  end

  a_ack: assert property (
    @(posedge clk) disable iff (!rst_n)
    reg_rd_valid |=> reg_rd_ack
  ) else begin
    $display("%s: read ack missing one cycle after the request", test_name);
    err_ack++;
  end

  // selection rule, keys and constant compare unsigned
  function automatic logic passes(stream_pkg::pred_op_t op, logic [15:0] c, logic [15:0] k);
    case (op)
      stream_pkg::less:    return k < c;
      stream_pkg::equal:   return k == c;
      stream_pkg::greater: return k > c;
      default:             return 1'b1;
    endcase
  endfunction

  function automatic int total_errors();
    return err_order + err_hold + err_ack + err_reg;
  endfunction

  // all tasks start and end 1 ns after a rising edge
  task automatic idle(input int n);
    repeat (n) begin
      @(posedge clk);
      #1;
    end
  endtask

  task automatic write_reg(input logic [1:0] addr, input logic [31:0] data);
    reg_wr.addr  = addr;
    reg_wr.data  = data;
    reg_wr_valid = 1'b1;
    idle(1);
    reg_wr_valid = 1'b0;
  endtask

  task automatic read_check(input logic [1:0] addr, input logic [31:0] exp, input string what);
    reg_rd.addr  = addr;
    reg_rd_valid = 1'b1;
    idle(1);
    reg_rd_valid = 1'b0;
    n_reg_checks++;
    assert (reg_rd_ack && reg_rd_data == exp) else begin
      if (!reg_rd_ack)
        $display("%s: no read ack for %s", test_name, what);
      else
        $display("error %s %s expected %h actual %h", test_name, what, exp, reg_rd_data);
      err_reg++;
    end
  endtask

  task automatic set_pred(input stream_pkg::pred_op_t op, input logic [15:0] c);
    write_reg(`SEL_ADDR_CTRL, 32'(op));
    write_reg(`SEL_ADDR_CONST, {16'd0, c});
    cur_op    = op;
    cur_const = c;
  endtask

  // model first, then hold valid until in_ready was seen at an edge
  task automatic send(input stream_pkg::tuple_t t);
    logic taken;
    if (passes(cur_op, cur_const, t.key)) begin
      exp_q.push_back(t);
      matched_model++;
    end else begin
      dropped_model++;
    end
    in_data  = t;
    in_valid = 1'b1;
    taken    = 1'b0;
    while (!taken) begin
      taken = in_ready;
      idle(1);
    end
    in_valid = 1'b0;
  endtask

  task automatic drain();
    while (rd_idx != exp_q.size()) begin
      idle(1);
    end
    // dropped tuples behind the last match still have to clear the filter
    idle(2 ** `SEL_FIFO_DEPTH_BITS + 4);
  endtask

  task automatic run_stream(input int n, input bit gaps);
    stream_pkg::tuple_t t;
    for (int i = 0; i < n; i++) begin
      t.key   = 16'($urandom);
      t.value = $urandom;
      // every fourth key sits right on the constant
      if (i % 4 == 0) t.key = cur_const;
      if (gaps) idle($urandom_range(0, 2));
      send(t);
    end
    drain();
  endtask

  task automatic finish_test();
    $display("test %s done, %0d errors so far", test_name, total_errors());
    n_tests++;
  endtask

  initial begin
    void'($urandom(32'hb78f4dce));
    rst_n        = 1'b0;
    in_data      = '0;
    in_valid     = 1'b0;
    reg_wr       = '0;
    reg_wr_valid = 1'b0;
    reg_rd       = '0;
    reg_rd_valid = 1'b0;
    repeat (8) @(posedge clk);
    #1;
    rst_n = 1'b1;
    // FIFO ready comes up one edge later
    idle(1);

    n_reg_checks++;
    assert (!out_valid && !reg_rd_ack && in_ready) else begin
      $display("reset: outputs not idle after reset");
      err_reg++;
    end
    read_check(`SEL_ADDR_MATCHED, 32'd0, "matched");
    read_check(`SEL_ADDR_DROPPED, 32'd0, "dropped");
    finish_test();

    test_name = "pass_all";
    set_pred(stream_pkg::pass_all, 16'h0000);
    run_stream(20, 1'b0);
    finish_test();

    test_name = "predicates";
    set_pred(stream_pkg::less, 16'h4000);
    run_stream(30, 1'b0);
    set_pred(stream_pkg::equal, 16'h8000);
    run_stream(30, 1'b0);
    set_pred(stream_pkg::greater, 16'hc000);
    run_stream(30, 1'b0);
    finish_test();

    test_name = "backpressure";
    set_pred(stream_pkg::greater, 16'h8000);
    stall_on = 1'b1;
    run_stream(40, 1'b1);
    stall_on = 1'b0;
    finish_test();

    test_name = "counters";
    read_check(`SEL_ADDR_MATCHED, 32'(matched_model), "matched");
    read_check(`SEL_ADDR_DROPPED, 32'(dropped_model), "dropped");
    finish_test();

    test_name = "readback";
    write_reg(`SEL_ADDR_CTRL, 32'(stream_pkg::equal));
    read_check(`SEL_ADDR_CTRL, 32'(stream_pkg::equal), "ctrl");
    write_reg(`SEL_ADDR_CONST, 32'h0000_beef);
    read_check(`SEL_ADDR_CONST, 32'h0000_beef, "const");
    // counters are read only
    write_reg(`SEL_ADDR_MATCHED, 32'h0000_5a5a);
    read_check(`SEL_ADDR_MATCHED, 32'(matched_model), "matched");
    write_reg(`SEL_ADDR_DROPPED, 32'h0000_a5a5);
    read_check(`SEL_ADDR_DROPPED, 32'(dropped_model), "dropped");
    finish_test();

    $display("tests %0d, transfers %0d, register checks %0d, errors %0d",
             n_tests, n_xfers, n_reg_checks, total_errors());
    if (total_errors() == 0) begin
      $display("ALL CHECKS PASSED");
    end else begin
      $display("CHECKS FAILED");
    end
    $finish;
  end

endmodule

//--- select_top.f
+incdir+.
stream_pkg.sv
cfg_pkg.sv
reg_fifo.sv
select_cfg.sv
select_filter.sv
select_top.sv
select_tb.sv

//--- run_sim.sh
#!/usr/bin/env bash
# build and run the selection testbench with Verilator
cd "$(dirname "$0")" || exit 1

if ! verilator --binary --timing --assert -f select_top.f --top-module select_tb; then
  echo "verilator build failed"
  exit 1
fi

out=$(./obj_dir/Vselect_tb)
status=$?
echo "$out"
if [ "$status" -ne 0 ]; then
  echo "simulation exited with status $status"
  exit 1
fi

if grep -qx "ALL CHECKS PASSED" <<< "$out"; then
  exit 0
fi
exit 1
